// ==== exe_pkg.sv ====
package exe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;
    localparam int div_steps  = 32;
    localparam int div_cnt_w  = $clog2(div_steps);
    localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(div_steps - 1);

    // one-hot, op_add is bit 0 and op_lui bit 11
    typedef struct packed {
        logic op_lui;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic op_sltu;
        logic op_slt;
        logic op_sub;
        logic op_add;
    } alu_op_t;

    typedef struct packed {
        logic rsvd;
        logic is_swr;   // also lwr
        logic is_swl;   // also lwl
        logic is_half;
        logic is_byte;
        logic is_word;
    } ls_type_t;

    typedef struct packed {
        logic mtlo;
        logic mthi;
        logic mflo;
        logic mfhi;
        logic divu;
        logic div;
        logic multu;
        logic mult;
    } md_op_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   src1_is_sa;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_8;
        logic [15:0]            imm;
        logic [xlen-1:0]        rs_value;
        logic [xlen-1:0]        rt_value;
        logic [xlen-1:0]        pc;
        logic [reg_addr_w-1:0]  dest;
        logic                   gpr_we;
        logic                   mem_re;
        logic                   mem_we;
        ls_type_t               ls_type;
        md_op_t                 md_op;
    } ds_to_es_t;

    typedef struct packed {
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        result;
        logic [reg_addr_w-1:0]  dest;
        logic                   gpr_we;
        logic                   mem_re;
        ls_type_t               ls_type;
        logic [1:0]             lad;        // address bits 1:0 for load alignment
        logic [xlen-1:0]        rt_value;
    } es_to_ms_t;

    typedef struct packed {
        logic                   wr;
        logic [1:0]             size;       // 0 byte, 1 half, 2 word
        logic [xlen-1:0]        addr;
        logic [3:0]             wstrb;
        logic [xlen-1:0]        wdata;
    } data_req_t;

endpackage

// ==== exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::alu_op_t         alu_op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    output logic [exe_pkg::xlen-1:0] result
);

    logic [exe_pkg::alu_op_w-1:0] op_bits;
    logic                         adder_inv;
    logic [exe_pkg::xlen-1:0]     adder_b;
    logic [exe_pkg::xlen-1:0]     adder_sum;
    logic                         adder_cout;
    logic                         slt_res;
    logic                         sltu_res;
    logic [4:0]                   shamt;
    logic [exe_pkg::xlen-1:0]     sra_res;

    assign op_bits   = alu_op;
    assign adder_inv = alu_op.op_sub | alu_op.op_slt | alu_op.op_sltu; // a + ~b + 1
    assign adder_b   = adder_inv ? ~src2 : src2;

    assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b}
                                   + {{exe_pkg::xlen{1'b0}}, adder_inv};

    // signed compare from operand signs and the difference sign
    assign slt_res  = (src1[exe_pkg::xlen-1] & ~src2[exe_pkg::xlen-1])
                    | (~(src1[exe_pkg::xlen-1] ^ src2[exe_pkg::xlen-1])
                       & adder_sum[exe_pkg::xlen-1]);
    assign sltu_res = ~adder_cout;                                      // borrow out

    assign shamt   = src1[4:0];
    assign sra_res = $signed(src2) >>> shamt;

    assign result = ({exe_pkg::xlen{alu_op.op_add | alu_op.op_sub}} & adder_sum)
                  | ({exe_pkg::xlen{alu_op.op_slt}}  & {{(exe_pkg::xlen-1){1'b0}}, slt_res})
                  | ({exe_pkg::xlen{alu_op.op_sltu}} & {{(exe_pkg::xlen-1){1'b0}}, sltu_res})
                  | ({exe_pkg::xlen{alu_op.op_and}}  & (src1 & src2))
                  | ({exe_pkg::xlen{alu_op.op_nor}}  & ~(src1 | src2))
                  | ({exe_pkg::xlen{alu_op.op_or}}   & (src1 | src2))
                  | ({exe_pkg::xlen{alu_op.op_xor}}  & (src1 ^ src2))
                  | ({exe_pkg::xlen{alu_op.op_sll}}  & (src2 << shamt))
                  | ({exe_pkg::xlen{alu_op.op_srl}}  & (src2 >> shamt))
                  | ({exe_pkg::xlen{alu_op.op_sra}}  & sra_res)
                  | ({exe_pkg::xlen{alu_op.op_lui}}  & {src2[15:0], 16'b0});

    // md-only instructions carry no alu op, so zero bits is legal
    always_comb begin
        assert ($onehot0(op_bits))
        else $error("alu_op has more than one operation bit set: %b", op_bits);
    end

endmodule

// ==== exe_divider.sv ====
`timescale 1ns/1ps

module exe_divider (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     is_signed,
    input  logic [exe_pkg::xlen-1:0] dividend,
    input  logic [exe_pkg::xlen-1:0] divisor,
    output logic                     busy,
    output logic                     done,
    output logic [exe_pkg::xlen-1:0] quotient,
    output logic [exe_pkg::xlen-1:0] remainder
);

    logic [exe_pkg::xlen-1:0]      dvd_mag;
    logic [exe_pkg::xlen-1:0]      dvs_mag;
    logic [exe_pkg::xlen-1:0]      quo_r;       // dividend shifts out, quotient shifts in
    logic [exe_pkg::xlen-1:0]      rem_r;
    logic [exe_pkg::xlen-1:0]      dvs_r;
    logic                          quo_neg;
    logic                          rem_neg;
    logic [exe_pkg::div_cnt_w-1:0] step_cnt;
    logic [exe_pkg::xlen:0]        shifted;
    logic [exe_pkg::xlen:0]        trial;

    assign dvd_mag = (is_signed && dividend[exe_pkg::xlen-1]) ? -dividend : dividend;
    assign dvs_mag = (is_signed && divisor[exe_pkg::xlen-1])  ? -divisor  : divisor;

    assign shifted = {rem_r, quo_r[exe_pkg::xlen-1]};
    assign trial   = shifted - {1'b0, dvs_r};       // negative means restore

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == exe_pkg::div_last) begin
                    busy <= 1'b0;
                    done <= 1'b1;                   // single-cycle pulse
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_r   <= dvd_mag;
            rem_r   <= '0;
            dvs_r   <= dvs_mag;
            quo_neg <= is_signed & (dividend[exe_pkg::xlen-1] ^ divisor[exe_pkg::xlen-1]);
            rem_neg <= is_signed & dividend[exe_pkg::xlen-1];
        end else if (busy) begin
            rem_r <= trial[exe_pkg::xlen] ? shifted[exe_pkg::xlen-1:0]
                                          : trial[exe_pkg::xlen-1:0];
            quo_r <= {quo_r[exe_pkg::xlen-2:0], ~trial[exe_pkg::xlen]};
        end
    end

    // remainder follows the dividend sign
    assign quotient  = quo_neg ? -quo_r : quo_r;
    assign remainder = rem_neg ? -rem_r : rem_r;

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy)
    else $error("divider started while a divide is still running");

endmodule

// ==== exe_hilo.sv ====
`timescale 1ns/1ps

module exe_hilo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     active,
    input  exe_pkg::md_op_t          md_op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    input  logic [exe_pkg::xlen-1:0] rs_value,
    output logic [exe_pkg::xlen-1:0] hi,
    output logic [exe_pkg::xlen-1:0] lo,
    output logic                     md_ready
);

    logic                            is_div;
    logic                            issued;
    logic                            div_start;
    logic                            div_busy;
    logic                            div_done;
    logic [exe_pkg::xlen-1:0]        div_quo;
    logic [exe_pkg::xlen-1:0]        div_rem;
    logic signed [exe_pkg::xlen:0]   mul_a;
    logic signed [exe_pkg::xlen:0]   mul_b;
    logic signed [2*exe_pkg::xlen+1:0] product;

    assign is_div = md_op.div | md_op.divu;

    // 33-bit operands, extra bit is the sign only for mult
    assign mul_a   = {md_op.mult & src1[exe_pkg::xlen-1], src1};
    assign mul_b   = {md_op.mult & src2[exe_pkg::xlen-1], src2};
    assign product = mul_a * mul_b;

    assign div_start = active & is_div & ~issued & ~div_busy;
    assign md_ready  = ~(active & is_div & ~div_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            issued <= 1'b0;
        end else if (div_done) begin
            issued <= 1'b0;
        end else if (div_start) begin
            issued <= 1'b1;                 // one start per divide
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            hi <= div_rem;
            lo <= div_quo;
        end else if (active && (md_op.mult || md_op.multu)) begin
            hi <= product[2*exe_pkg::xlen-1:exe_pkg::xlen];
            lo <= product[exe_pkg::xlen-1:0];
        end else if (active && md_op.mthi) begin
            hi <= rs_value;
        end else if (active && md_op.mtlo) begin
            lo <= rs_value;
        end
    end

    exe_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (md_op.div),
        .dividend  (src1),
        .divisor   (src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

endmodule

// ==== exe_store_format.sv ====
`timescale 1ns/1ps

module exe_store_format (
    input  exe_pkg::ls_type_t        ls_type,
    input  logic [1:0]               lad,
    input  logic [exe_pkg::xlen-1:0] rt_value,
    output logic [3:0]               wstrb,
    output logic [exe_pkg::xlen-1:0] wdata,
    output logic [1:0]               size
);

    logic [2:0] strb_cnt;

    always_comb begin
        wstrb = 4'b0000;
        wdata = rt_value;
        if (ls_type.is_word) begin
            wstrb = 4'b1111;
        end else if (ls_type.is_half) begin
            wstrb = lad[1] ? 4'b1100 : 4'b0011;
            wdata = {2{rt_value[15:0]}};                // replicated to both halves
        end else if (ls_type.is_byte) begin
            wstrb = 4'b0001 << lad;
            wdata = {4{rt_value[7:0]}};
        end else if (ls_type.is_swl) begin
            // upper register bytes land at and below the address
            wstrb = 4'b1111 >> (2'd3 - lad);
            wdata = rt_value >> {~lad, 3'b000};
        end else if (ls_type.is_swr) begin
            // lower register bytes land at and above the address
            wstrb = 4'b1111 << lad;
            wdata = rt_value << {lad, 3'b000};
        end
    end

    assign strb_cnt = {2'b00, wstrb[0]} + {2'b00, wstrb[1]}
                    + {2'b00, wstrb[2]} + {2'b00, wstrb[3]};

    always_comb begin
        case (strb_cnt)
            3'd1:    size = 2'd0;                       // byte
            3'd2:    size = 2'd1;                       // half
            default: size = 2'd2;                       // three or four lanes go as word
        endcase
    end

endmodule

// ==== exe_mem_request.sv ====
`timescale 1ns/1ps

module exe_mem_request (
    input  logic clk,
    input  logic reset,
    input  logic launch,
    input  logic leave,
    input  logic addr_ok,
    output logic req,
    output logic handshake_done
);

    always_ff @(posedge clk) begin
        if (reset) begin
            req <= 1'b0;
        end else if (req && addr_ok) begin
            req <= 1'b0;                            // accepted
        end else if (!req && !handshake_done) begin
            req <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            handshake_done <= 1'b0;
        end else if (leave) begin
            handshake_done <= 1'b0;                 // instruction moved on
        end else if (req && addr_ok) begin
            handshake_done <= 1'b1;
        end
    end

    // the instruction stays in the stage until its request is taken
    a_req_held_instr: assert property (@(posedge clk) disable iff (reset)
        req |-> launch && !leave)
    else $error("instruction left the stage with its memory request still pending");

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_to_es_valid,
    input  exe_pkg::ds_to_es_t ds_to_es_bus,
    output logic               es_allowin,
    output logic               es_to_ms_valid,
    output exe_pkg::es_to_ms_t es_to_ms_bus,
    input  logic               ms_allowin,
    output logic               data_sram_req,
    output exe_pkg::data_req_t data_sram,
    input  logic               data_sram_addr_ok
);

    exe_pkg::ds_to_es_t       ds_r;
    logic                     es_valid;
    logic                     es_ready_go;
    logic                     hilo_written;
    logic                     hilo_active;
    logic                     md_ready;
    logic                     mem_launch;
    logic                     mem_leave;
    logic                     mem_done;
    logic                     mem_done_flag;
    logic                     src2_is_uimm;
    logic [exe_pkg::xlen-1:0] imm_ext;
    logic [exe_pkg::xlen-1:0] alu_src1;
    logic [exe_pkg::xlen-1:0] alu_src2;
    logic [exe_pkg::xlen-1:0] alu_result;
    logic [exe_pkg::xlen-1:0] hi;
    logic [exe_pkg::xlen-1:0] lo;
    logic [exe_pkg::xlen-1:0] st_wdata;
    logic [3:0]               st_wstrb;
    logic [1:0]               st_size;

    assign mem_done    = ~(ds_r.mem_re | ds_r.mem_we) | mem_done_flag;
    assign es_ready_go = md_ready & mem_done;
    assign es_allowin  = ~es_valid | (es_ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid & es_ready_go;
    assign mem_launch  = es_valid & (ds_r.mem_re | ds_r.mem_we);
    assign mem_leave   = es_to_ms_valid & ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            ds_r <= ds_to_es_bus;
        end
    end

    // keeps HI/LO writes to one per instruction while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            hilo_written <= 1'b0;
        end else if (es_allowin) begin
            hilo_written <= 1'b0;
        end else if (es_valid && md_ready) begin
            hilo_written <= 1'b1;
        end
    end
    assign hilo_active = es_valid & ~hilo_written;

    // andi, ori and xori zero-extend
    assign src2_is_uimm = ds_r.src2_is_imm
                        & (ds_r.alu_op.op_and | ds_r.alu_op.op_or | ds_r.alu_op.op_xor);
    assign imm_ext  = {{16{~src2_is_uimm & ds_r.imm[15]}}, ds_r.imm};
    assign alu_src1 = ds_r.src1_is_sa  ? {27'b0, ds_r.imm[10:6]} :
                      ds_r.src1_is_pc  ? ds_r.pc                 : ds_r.rs_value;
    assign alu_src2 = ds_r.src2_is_imm ? imm_ext                 :
                      ds_r.src2_is_8   ? 32'd8                   : ds_r.rt_value;

    always_comb begin
        es_to_ms_bus.pc       = ds_r.pc;
        es_to_ms_bus.result   = ds_r.md_op.mfhi ? hi :
                                ds_r.md_op.mflo ? lo : alu_result;
        es_to_ms_bus.dest     = ds_r.dest;
        es_to_ms_bus.gpr_we   = ds_r.gpr_we;
        es_to_ms_bus.mem_re   = ds_r.mem_re;
        es_to_ms_bus.ls_type  = ds_r.ls_type;
        es_to_ms_bus.lad      = alu_result[1:0];
        es_to_ms_bus.rt_value = ds_r.rt_value;
    end

    always_comb begin
        data_sram.wr    = ds_r.mem_we;
        data_sram.size  = st_size;
        data_sram.addr  = alu_result;               // alu computes base + offset
        data_sram.wstrb = {4{ds_r.mem_we}} & st_wstrb;
        data_sram.wdata = st_wdata;
    end

    exe_alu u_alu (
        .alu_op (ds_r.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    exe_hilo u_hilo (
        .clk      (clk),
        .reset    (reset),
        .active   (hilo_active),
        .md_op    (ds_r.md_op),
        .src1     (alu_src1),
        .src2     (alu_src2),
        .rs_value (ds_r.rs_value),
        .hi       (hi),
        .lo       (lo),
        .md_ready (md_ready)
    );

    exe_store_format u_store_format (
        .ls_type  (ds_r.ls_type),
        .lad      (alu_result[1:0]),
        .rt_value (ds_r.rt_value),
        .wstrb    (st_wstrb),
        .wdata    (st_wdata),
        .size     (st_size)
    );

    exe_mem_request u_mem_request (
        .clk            (clk),
        .reset          (reset),
        .launch         (mem_launch),
        .leave          (mem_leave),
        .addr_ok        (data_sram_addr_ok),
        .req            (data_sram_req),
        .handshake_done (mem_done_flag)
    );

    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_to_ms_bus))
    else $error("es_to_ms bus changed while the memory stage was stalled");

endmodule

// ==== tb_exe_model.sv ====
package tb_exe_model;

    // architectural HI/LO as the model sees them, in program order
    logic [exe_pkg::xlen-1:0] model_hi = '0;
    logic [exe_pkg::xlen-1:0] model_lo = '0;

    task automatic rand_word(inout integer seed, output logic [31:0] value);
        integer pick;
        pick = $unsigned($random(seed)) % 8;
        case (pick)
            0:       value = 32'h8000_0000;     // most negative
            1:       value = 32'hffff_ffff;     // minus one
            default: value = $random(seed);
        endcase
    endtask

    function automatic logic [31:0] eval_alu(exe_pkg::alu_op_t op, logic [31:0] a,
                                             logic [31:0] b);
        logic [31:0] r;
        r = '0;
        if (op.op_add)  r = a + b;
        if (op.op_sub)  r = a - b;
        if (op.op_slt)  r = {31'b0, $signed(a) < $signed(b)};
        if (op.op_sltu) r = {31'b0, a < b};
        if (op.op_and)  r = a & b;
        if (op.op_nor)  r = ~(a | b);
        if (op.op_or)   r = a | b;
        if (op.op_xor)  r = a ^ b;
        if (op.op_sll)  r = b << a[4:0];
        if (op.op_srl)  r = b >> a[4:0];
        if (op.op_sra)  r = $unsigned($signed(b) >>> a[4:0]);
        if (op.op_lui)  r = {b[15:0], 16'h0000};
        return r;
    endfunction

    // lane strobe and data placement for one access type at one offset
    task automatic format_store(input exe_pkg::ls_type_t t, input logic [1:0] off,
                                input logic [31:0] rt, output logic [3:0] strb,
                                output logic [31:0] wdata, output logic [1:0] size);
        strb  = 4'b0000;
        wdata = rt;
        for (int i = 0; i < 4; i++) begin
            if (t.is_word) strb[i] = 1'b1;
            if (t.is_half) strb[i] = ((i / 2) == int'(off[1]));
            if (t.is_byte) strb[i] = (i == int'(off));
            if (t.is_swl)  strb[i] = (i <= int'(off));  // bytes at and below the address
            if (t.is_swr)  strb[i] = (i >= int'(off));  // bytes at and above it
        end
        if (t.is_half) wdata = {rt[15:0], rt[15:0]};
        if (t.is_byte) wdata = {4{rt[7:0]}};
        if (t.is_swl)  wdata = rt >> (8 * (3 - int'(off)));
        if (t.is_swr)  wdata = rt << (8 * int'(off));
        case ($countones(strb))
            1:       size = 2'd0;
            2:       size = 2'd1;
            default: size = 2'd2;
        endcase
    endtask

    task automatic gen_instr(inout integer seed, output exe_pkg::ds_to_es_t d);
        integer      kind;
        integer      sel;
        logic [31:0] value;
        d = '0;
        rand_word(seed, value);
        d.rs_value = value;
        rand_word(seed, value);
        d.rt_value = value;
        d.pc   = {30'($random(seed)), 2'b00};
        d.imm  = 16'($random(seed));
        d.dest = 5'($random(seed));
        kind   = $unsigned($random(seed)) % 100;
        sel    = $unsigned($random(seed)) % 12;
        if (kind < 50) begin
            d.alu_op = exe_pkg::alu_op_t'(12'b1 << sel);
            case ($unsigned($random(seed)) % 4)
                2:       d.src1_is_sa = 1'b1;
                3:       d.src1_is_pc = 1'b1;
                default: d.src1_is_sa = 1'b0;
            endcase
            case ($unsigned($random(seed)) % 4)
                2:       d.src2_is_imm = 1'b1;
                3:       d.src2_is_8 = 1'b1;
                default: d.src2_is_imm = 1'b0;
            endcase
            if (d.alu_op.op_lui) begin
                d.src2_is_imm = 1'b1;
                d.src2_is_8   = 1'b0;
            end
            d.gpr_we = 1'b1;
        end else if (kind < 58) begin
            d.md_op.mult  = (sel % 2) == 0;
            d.md_op.multu = (sel % 2) == 1;
        end else if (kind < 64) begin
            d.md_op.div  = (sel % 2) == 0;
            d.md_op.divu = (sel % 2) == 1;
            while (d.rt_value == 32'h0) begin
                d.rt_value = $random(seed);
            end
        end else if (kind < 72) begin
            d.md_op.mfhi = (sel % 2) == 0;
            d.md_op.mflo = (sel % 2) == 1;
            d.gpr_we     = 1'b1;
        end else if (kind < 76) begin
            d.md_op.mthi = (sel % 2) == 0;
            d.md_op.mtlo = (sel % 2) == 1;
        end else begin
            d.alu_op.op_add = 1'b1;     // base plus offset
            d.src2_is_imm   = 1'b1;
            if (kind < 88) begin
                d.mem_we  = 1'b1;
                d.ls_type = exe_pkg::ls_type_t'(6'b1 << (sel % 5));
            end else begin
                d.mem_re  = 1'b1;
                d.gpr_we  = 1'b1;
                d.ls_type = exe_pkg::ls_type_t'(6'b1 << (sel % 3));
            end
        end
    endtask

    task automatic run_model(input exe_pkg::ds_to_es_t d, output exe_pkg::es_to_ms_t o,
                             output exe_pkg::data_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] alu_res;
        logic [63:0] prod;
        longint      dvd;
        longint      dvs;
        longint      quo;
        longint      rem;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [1:0]  size;
        bit          zero_ext;
        zero_ext = d.src2_is_imm && (d.alu_op.op_and || d.alu_op.op_or || d.alu_op.op_xor);
        if (d.src1_is_sa)      a = {27'b0, d.imm[10:6]};
        else if (d.src1_is_pc) a = d.pc;
        else                   a = d.rs_value;
        if (d.src2_is_imm)     b = zero_ext ? {16'h0, d.imm} : {{16{d.imm[15]}}, d.imm};
        else if (d.src2_is_8)  b = 32'd8;
        else                   b = d.rt_value;
        alu_res = eval_alu(d.alu_op, a, b);

        o          = '0;
        o.pc       = d.pc;
        o.result   = d.md_op.mfhi ? model_hi : d.md_op.mflo ? model_lo : alu_res;
        o.dest     = d.dest;
        o.gpr_we   = d.gpr_we;
        o.mem_re   = d.mem_re;
        o.ls_type  = d.ls_type;
        o.lad      = alu_res[1:0];
        o.rt_value = d.rt_value;

        if (d.md_op.mult || d.md_op.multu) begin
            if (d.md_op.mult) prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            else              prod = {32'h0, a} * {32'h0, b};
            model_hi = prod[63:32];
            model_lo = prod[31:0];
        end else if (d.md_op.div || d.md_op.divu) begin
            dvd = d.md_op.div ? longint'($signed(a)) : longint'({32'h0, a});
            dvs = d.md_op.div ? longint'($signed(b)) : longint'({32'h0, b});
            quo = dvd / dvs;                // truncates toward zero
            rem = dvd % dvs;                // sign of the dividend
            model_lo = quo[31:0];
            model_hi = rem[31:0];
        end else if (d.md_op.mthi) begin
            model_hi = d.rs_value;
        end else if (d.md_op.mtlo) begin
            model_lo = d.rs_value;
        end

        format_store(d.ls_type, alu_res[1:0], d.rt_value, strb, wdata, size);
        r.wr    = d.mem_we;
        r.size  = size;
        r.addr  = alu_res;
        r.wstrb = d.mem_we ? strb : 4'b0000;    // loads write no lane
        r.wdata = wdata;
    endtask

    task automatic check_es_to_ms(input string name, input exe_pkg::es_to_ms_t expected,
                                  input exe_pkg::es_to_ms_t actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h (pc %h)",
                     $time, name, expected, actual, expected.pc);
        end
    endtask

    task automatic check_data_req(input string name, input exe_pkg::data_req_t expected,
                                  input exe_pkg::data_req_t actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("Mismatch at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual,
                              output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("Mismatch at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

endpackage

// ==== tb_exe_stage.sv ====
`timescale 1ns/1ps

module tb_exe_stage;

    localparam int num_instr    = 200;
    localparam int reset_cycles = 8;
    localparam int cycle_limit  = num_instr * 40;

    logic               clk;
    logic               reset;
    logic               ds_to_es_valid;
    exe_pkg::ds_to_es_t ds_to_es_bus;
    logic               es_allowin;
    logic               es_to_ms_valid;
    exe_pkg::es_to_ms_t es_to_ms_bus;
    logic               ms_allowin;
    logic               data_sram_req;
    exe_pkg::data_req_t data_sram;
    logic               data_sram_addr_ok;

    integer             seed;
    int                 n_issued = 0;
    int                 n_accepted = 0;
    int                 n_out = 0;
    int                 cycle_cnt = 0;
    bit                 ok;
    bit                 out_stalled = 1'b0;
    bit                 req_stalled = 1'b0;
    exe_pkg::ds_to_es_t instr;
    exe_pkg::es_to_ms_t held_out;
    exe_pkg::es_to_ms_t new_out;
    exe_pkg::data_req_t held_req;
    exe_pkg::data_req_t new_req;
    exe_pkg::es_to_ms_t out_q[$];    // expected transfers in program order
    exe_pkg::data_req_t req_q[$];    // expected requests, loads and stores only

    exe_stage u_dut (
        .clk               (clk),
        .reset             (reset),
        .ds_to_es_valid    (ds_to_es_valid),
        .ds_to_es_bus      (ds_to_es_bus),
        .es_allowin        (es_allowin),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .ms_allowin        (ms_allowin),
        .data_sram_req     (data_sram_req),
        .data_sram         (data_sram),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // sampled before the edge updates, inputs only move on the falling edge
    always @(posedge clk) begin
        if (!reset) begin
            // empty stage, or the held instruction leaves on this edge
            tb_exe_model::check_flag("es_allowin",
                                     (n_accepted == n_out) || (es_to_ms_valid && ms_allowin),
                                     es_allowin, ok);
            if (!ok) stop_with_failure();
            if (out_stalled) begin
                if (!es_to_ms_valid) begin
                    $display("es_to_ms_valid dropped while the memory stage was stalled");
                    stop_with_failure();
                end
                tb_exe_model::check_es_to_ms("es_to_ms_bus (stalled)", held_out,
                                             es_to_ms_bus, ok);
                if (!ok) stop_with_failure();
            end
            if (req_stalled) begin
                if (!data_sram_req) begin
                    $display("data_sram_req dropped before addr_ok accepted it");
                    stop_with_failure();
                end
                tb_exe_model::check_data_req("data_sram (waiting)", held_req, data_sram, ok);
                if (!ok) stop_with_failure();
            end
            if (es_to_ms_valid && ms_allowin) begin
                if (out_q.size() == 0) begin
                    $display("an instruction reached the memory stage with none outstanding");
                    stop_with_failure();
                end else begin
                    tb_exe_model::check_es_to_ms("es_to_ms_bus", out_q.pop_front(),
                                                 es_to_ms_bus, ok);
                    if (!ok) stop_with_failure();
                    n_out++;
                end
            end
            if (data_sram_req && data_sram_addr_ok) begin
                if (req_q.size() == 0) begin
                    $display("a memory request was accepted with no load or store pending");
                    stop_with_failure();
                end else begin
                    tb_exe_model::check_data_req("data_sram", req_q.pop_front(), data_sram, ok);
                    if (!ok) stop_with_failure();
                end
            end
            out_stalled = es_to_ms_valid && !ms_allowin;
            held_out    = es_to_ms_bus;
            req_stalled = data_sram_req && !data_sram_addr_ok;
            held_req    = data_sram;
            if (ds_to_es_valid && es_allowin) begin
                tb_exe_model::run_model(ds_to_es_bus, new_out, new_req);
                out_q.push_back(new_out);
                if (ds_to_es_bus.mem_re || ds_to_es_bus.mem_we) begin
                    req_q.push_back(new_req);
                end
                n_accepted++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout: only %0d of %0d instructions left the stage in %0d cycles",
                     n_out, num_instr, cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        seed              = 32'hea9c_66c9;
        reset             = 1'b1;
        ds_to_es_valid    = 1'b0;
        ds_to_es_bus      = '0;
        ms_allowin        = 1'b0;
        data_sram_addr_ok = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (n_out < num_instr) begin
            @(negedge clk);
            ms_allowin        = ($unsigned($random(seed)) % 4) != 0;    // back-pressure
            data_sram_addr_ok = ($unsigned($random(seed)) % 4) != 0;
            if (n_accepted == n_issued) begin                           // nothing held
                if (n_issued < num_instr && ($unsigned($random(seed)) % 8) != 0) begin
                    tb_exe_model::gen_instr(seed, instr);
                    ds_to_es_bus   = instr;
                    ds_to_es_valid = 1'b1;
                    n_issued++;
                end else begin
                    ds_to_es_valid = 1'b0;                              // bubble
                end
            end
        end
        repeat (4) @(negedge clk);
        if (req_q.size() != 0 || out_q.size() != 0) begin
            $display("%0d memory requests and %0d transfers never appeared",
                     req_q.size(), out_q.size());
            stop_with_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== files.f ====
exe_pkg.sv
exe_alu.sv
exe_divider.sv
exe_hilo.sv
exe_store_format.sv
exe_mem_request.sv
exe_stage.sv
tb_exe_model.sv
tb_exe_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_exe_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
